// ==== dt_coef_top.f ====
+incdir+hdl
hdl/fp_mul_pkg.sv
hdl/dt_coef_pkg.sv
hdl/dt_step_rom.sv
hdl/dt_coef_seq.sv
hdl/dt_coef_bank.sv
hdl/dt_coef_top.sv
tests/dt_coef_mul_model.sv
tests/dt_coef_asserts.sv
tests/tb_dt_coef.sv

// ==== hdl/dt_coef_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dt_coef_config.svh"

module dt_coef_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  res_we,
    input  dt_coef_pkg::dest_t    res_dest,
    input  logic [`DT_WIDTH-1:0]  res_data,
    input  logic                  seq_start,
    input  logic                  seq_last,
    output dt_coef_pkg::coef_set_t coefs,
    output logic                  done,
    output logic                  valid
);
    import dt_coef_pkg::*;

    logic [`DT_WIDTH-1:0] coef_q [`NUM_COEFS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_COEFS; i++)
                coef_q[i] <= '0;
            done  <= 1'b0;
            valid <= 1'b0;
        end else begin
            done <= 1'b0;
            if (res_we && (res_dest < `NUM_COEFS))  // power-only writes skip the bank
                coef_q[res_dest] <= res_data;
            if (seq_start) begin
                valid <= 1'b0;
            end else if (res_we && seq_last) begin
                valid <= 1'b1;
                done  <= 1'b1;
            end
        end
    end

    always_comb begin
        coefs.delta_t2    = coef_q[D_DELTA_T2];
        coefs.dt2         = coef_q[D_DT2];
        coefs.half_dt2    = coef_q[D_HALF_DT2];
        coefs.three2_dt2  = coef_q[D_THREE2_DT2];
        coefs.half_dt3    = coef_q[D_HALF_DT3];
        coefs.third_dt3   = coef_q[D_THIRD_DT3];
        coefs.sixth_dt3   = coef_q[D_SIXTH_DT3];
        coefs.two3_dt3    = coef_q[D_TWO3_DT3];
        coefs.quarter_dt4 = coef_q[D_QUARTER_DT4];
        coefs.sixth_dt4   = coef_q[D_SIXTH_DT4];
        coefs.twelfth_dt4 = coef_q[D_TWELFTH_DT4];
        coefs.five12_dt4  = coef_q[D_FIVE12_DT4];
    end

endmodule

`default_nettype wire

// ==== hdl/dt_coef_config.svh ====
`ifndef DT_COEF_CONFIG_SVH
`define DT_COEF_CONFIG_SVH

// one IEEE-754 double
`define DT_WIDTH 64

// multiplier operations per sequence
`define NUM_STEPS 14

// published coefficient fields
`define NUM_COEFS 12

// --------------------
// scale factors, double bit patterns
// --------------------
`define FP_TWO            64'h4000_0000_0000_0000
`define FP_HALF           64'h3fe0_0000_0000_0000
`define FP_THREE_HALVES   64'h3ff8_0000_0000_0000
`define FP_THIRD          64'h3fd5_5555_5555_5555
`define FP_SIXTH          64'h3fc5_5555_5555_5555
`define FP_TWO_THIRDS     64'h3fe5_5555_5555_5555
`define FP_QUARTER        64'h3fd0_0000_0000_0000
`define FP_TWELFTH        64'h3fb5_5555_5555_5555

// 0.41666..., rounded to nearest
`define FP_FIVE_TWELFTHS  64'h3fda_aaaa_aaaa_aaab

`endif

// ==== hdl/dt_coef_pkg.sv ====
`default_nettype none

`include "dt_coef_config.svh"

package dt_coef_pkg;

    // operand source for one multiplier port
    typedef enum logic [2:0] {
        OP_DT,
        OP_DT2,
        OP_DT3,
        OP_DT4,
        OP_CONST
    } opnd_sel_t;

    // result destination
    // values below NUM_COEFS index the coefficient fields, in coef_set_t order
    typedef enum logic [3:0] {
        D_DELTA_T2,
        D_DT2,          // power register and coefficient field
        D_HALF_DT2,
        D_THREE2_DT2,
        D_HALF_DT3,
        D_THIRD_DT3,
        D_SIXTH_DT3,
        D_TWO3_DT3,
        D_QUARTER_DT4,
        D_SIXTH_DT4,
        D_TWELFTH_DT4,
        D_FIVE12_DT4,
        D_DT3,          // power only
        D_DT4           // power only
    } dest_t;

    typedef struct packed {
        opnd_sel_t            a_sel;
        opnd_sel_t            b_sel;
        logic [`DT_WIDTH-1:0] const_val;
        dest_t                dest;
    } step_t;

    typedef struct packed {
        logic [`DT_WIDTH-1:0] delta_t2;     // 2*dt
        logic [`DT_WIDTH-1:0] dt2;
        logic [`DT_WIDTH-1:0] half_dt2;
        logic [`DT_WIDTH-1:0] three2_dt2;
        logic [`DT_WIDTH-1:0] half_dt3;
        logic [`DT_WIDTH-1:0] third_dt3;
        logic [`DT_WIDTH-1:0] sixth_dt3;
        logic [`DT_WIDTH-1:0] two3_dt3;
        logic [`DT_WIDTH-1:0] quarter_dt4;
        logic [`DT_WIDTH-1:0] sixth_dt4;
        logic [`DT_WIDTH-1:0] twelfth_dt4;
        logic [`DT_WIDTH-1:0] five12_dt4;
    } coef_set_t;

endpackage

`default_nettype wire

// ==== hdl/dt_coef_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dt_coef_config.svh"

module dt_coef_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`DT_WIDTH-1:0]   delta_t,
    input  dt_coef_pkg::step_t     step,
    output logic [3:0]             step_idx,
    output logic                   mul_req_valid,
    input  logic                   mul_req_ready,
    output fp_mul_pkg::mul_req_t   mul_req,
    input  logic                   mul_resp_valid,
    output logic                   mul_resp_ready,
    input  fp_mul_pkg::mul_resp_t  mul_resp,
    output logic                   res_we,
    output dt_coef_pkg::dest_t     res_dest,
    output logic [`DT_WIDTH-1:0]   res_data,
    output logic                   seq_start,
    output logic                   seq_last
);
    import dt_coef_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t               state;
    logic                 restart_pend;  // old product still in flight
    logic [`DT_WIDTH-1:0] dt_q;
    logic [`DT_WIDTH-1:0] dt_next;       // dt held for a pending restart
    logic [`DT_WIDTH-1:0] pow2;
    logic [`DT_WIDTH-1:0] pow3;
    logic [`DT_WIDTH-1:0] pow4;
    logic                 req_fire;
    logic                 resp_fire;
    logic                 last_step;
    logic                 flush;
    logic                 res_wr;

    function automatic logic [`DT_WIDTH-1:0] opnd(input opnd_sel_t sel);
        unique case (sel)
            OP_DT:   return dt_q;
            OP_DT2:  return pow2;
            OP_DT3:  return pow3;
            OP_DT4:  return pow4;
            default: return step.const_val;
        endcase
    endfunction

    assign mul_req_valid  = (state == ST_REQ);
    assign mul_resp_ready = (state == ST_WAIT);
    assign req_fire       = mul_req_valid && mul_req_ready;
    assign resp_fire      = mul_resp_valid && mul_resp_ready;
    assign last_step      = (step_idx == 4'(`NUM_STEPS - 1));

    // product of an abandoned sequence is dropped
    assign flush  = resp_fire && (start || restart_pend);
    assign res_wr = resp_fire && !(start || restart_pend);

    always_comb begin
        mul_req.a = opnd(step.a_sel);
        mul_req.b = opnd(step.b_sel);
    end

    // --------------------
    // request/wait control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            step_idx     <= '0;
            restart_pend <= 1'b0;
            res_we       <= 1'b0;
            seq_start    <= 1'b0;
            seq_last     <= 1'b0;
        end else begin
            seq_start <= start;
            res_we    <= res_wr;
            seq_last  <= res_wr && last_step;
            unique case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_REQ;
                        step_idx <= '0;
                    end
                end
                ST_REQ: begin
                    // request stays up until taken, even across a restart
                    if (start)
                        restart_pend <= 1'b1;
                    if (req_fire)
                        state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (flush) begin
                        state        <= ST_REQ;
                        step_idx     <= '0;
                        restart_pend <= 1'b0;
                    end else if (res_wr) begin
                        state    <= last_step ? ST_IDLE : ST_REQ;
                        step_idx <= last_step ? 4'd0 : step_idx + 4'd1;
                    end else if (start) begin
                        restart_pend <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // dt latch, powers and result payload
    always_ff @(posedge clk) begin
        if (start)
            dt_next <= delta_t;
        if ((state == ST_IDLE && start) || flush)
            dt_q <= start ? delta_t : dt_next;
        if (res_wr) begin
            res_data <= mul_resp.y;
            res_dest <= step.dest;
            unique case (step.dest)
                D_DT2:   pow2 <= mul_resp.y;
                D_DT3:   pow3 <= mul_resp.y;
                D_DT4:   pow4 <= mul_resp.y;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dt_coef_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dt_coef_config.svh"

module dt_coef_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`DT_WIDTH-1:0]   delta_t,
    output logic                   mul_req_valid,
    input  logic                   mul_req_ready,
    output fp_mul_pkg::mul_req_t   mul_req,
    input  logic                   mul_resp_valid,
    output logic                   mul_resp_ready,
    input  fp_mul_pkg::mul_resp_t  mul_resp,
    output dt_coef_pkg::coef_set_t coefs,
    output logic                   done,
    output logic                   valid
);
    import dt_coef_pkg::*;

    logic [3:0]           step_idx;
    step_t                step;
    logic                 res_we;
    dest_t                res_dest;
    logic [`DT_WIDTH-1:0] res_data;
    logic                 seq_start;
    logic                 seq_last;

    dt_step_rom rom_i (
        .step_idx (step_idx),
        .step     (step)
    );

    dt_coef_seq seq_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .delta_t        (delta_t),
        .step           (step),
        .step_idx       (step_idx),
        .mul_req_valid  (mul_req_valid),
        .mul_req_ready  (mul_req_ready),
        .mul_req        (mul_req),
        .mul_resp_valid (mul_resp_valid),
        .mul_resp_ready (mul_resp_ready),
        .mul_resp       (mul_resp),
        .res_we         (res_we),
        .res_dest       (res_dest),
        .res_data       (res_data),
        .seq_start      (seq_start),
        .seq_last       (seq_last)
    );

    dt_coef_bank bank_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_we    (res_we),
        .res_dest  (res_dest),
        .res_data  (res_data),
        .seq_start (seq_start),
        .seq_last  (seq_last),
        .coefs     (coefs),
        .done      (done),
        .valid     (valid)
    );

endmodule

`default_nettype wire

// ==== hdl/dt_step_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dt_coef_config.svh"

module dt_step_rom (
    input  logic [3:0]          step_idx,
    output dt_coef_pkg::step_t  step
);
    import dt_coef_pkg::*;

    // each entry only reads powers written by an earlier step
    always_comb begin
        step = '0;
        unique case (step_idx)
            // dt^2 first, everything else builds on it
            4'd0:  step = '{OP_DT,  OP_DT,    '0,                D_DT2};
            4'd1:  step = '{OP_DT,  OP_CONST, `FP_TWO,           D_DELTA_T2};

            // --------------------
            // dt^2 group
            // --------------------
            4'd2:  step = '{OP_DT2, OP_CONST, `FP_HALF,          D_HALF_DT2};
            4'd3:  step = '{OP_DT2, OP_CONST, `FP_THREE_HALVES,  D_THREE2_DT2};
            4'd4:  step = '{OP_DT2, OP_DT,    '0,                D_DT3};

            // --------------------
            // dt^3 group
            // --------------------
            4'd5:  step = '{OP_DT3, OP_CONST, `FP_HALF,          D_HALF_DT3};
            4'd6:  step = '{OP_DT3, OP_CONST, `FP_THIRD,         D_THIRD_DT3};
            4'd7:  step = '{OP_DT3, OP_CONST, `FP_SIXTH,         D_SIXTH_DT3};
            4'd8:  step = '{OP_DT3, OP_CONST, `FP_TWO_THIRDS,    D_TWO3_DT3};
            4'd9:  step = '{OP_DT3, OP_DT,    '0,                D_DT4};

            // --------------------
            // dt^4 group
            // --------------------
            4'd10: step = '{OP_DT4, OP_CONST, `FP_QUARTER,       D_QUARTER_DT4};
            4'd11: step = '{OP_DT4, OP_CONST, `FP_SIXTH,         D_SIXTH_DT4};
            4'd12: step = '{OP_DT4, OP_CONST, `FP_TWELFTH,       D_TWELFTH_DT4};
            4'd13: step = '{OP_DT4, OP_CONST, `FP_FIVE_TWELFTHS, D_FIVE12_DT4};

            default: step = '0;    // unused indices
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/fp_mul_pkg.sv ====
`default_nettype none

`include "dt_coef_config.svh"

package fp_mul_pkg;

    // request to the shared multiplier
    typedef struct packed {
        logic [`DT_WIDTH-1:0] a;
        logic [`DT_WIDTH-1:0] b;
    } mul_req_t;

    // product back from the multiplier
    typedef struct packed {
        logic [`DT_WIDTH-1:0] y;
    } mul_resp_t;

endpackage

`default_nettype wire

// ==== tests/dt_coef_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module dt_coef_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 mul_req_valid,
    input logic                 mul_req_ready,
    input fp_mul_pkg::mul_req_t mul_req,
    input logic                 mul_resp_ready,
    input logic                 done,
    input logic                 valid
);
    int fail_count = 0;

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mul_req_valid && !mul_req_ready |=> mul_req_valid && $stable(mul_req))
        else begin
            fail_count++;
            $error("request dropped or changed before acceptance");
        end

    // one phase at a time
    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_resp_ready && mul_req_valid))
        else begin
            fail_count++;
            $error("mul_resp_ready high together with mul_req_valid");
        end

    done_valid: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> valid)
        else begin
            fail_count++;
            $error("done high while valid low");
        end

endmodule

bind dt_coef_top dt_coef_asserts asserts_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .mul_req_valid  (mul_req_valid),
    .mul_req_ready  (mul_req_ready),
    .mul_req        (mul_req),
    .mul_resp_ready (mul_resp_ready),
    .done           (done),
    .valid          (valid)
);

`default_nettype wire

// ==== tests/dt_coef_mul_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module dt_coef_mul_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_stall,   // holds ready low
    input  logic                  resp_stall,  // delays valid
    input  logic                  req_valid,
    output logic                  req_ready,
    input  fp_mul_pkg::mul_req_t  req,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output fp_mul_pkg::mul_resp_t resp
);
    import fp_mul_pkg::*;

    logic busy;  // one product in flight

    assign req_ready = !busy && !req_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            if (req_valid && req_ready) begin
                resp.y <= $realtobits($bitstoreal(req.a) * $bitstoreal(req.b));
                busy   <= 1'b1;
            end else if (resp_valid && resp_ready) begin
                busy       <= 1'b0;
                resp_valid <= 1'b0;
            end else if (busy && !resp_valid && !resp_stall) begin
                resp_valid <= 1'b1;  // valid held until taken
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_dt_coef.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dt_coef_config.svh"

module tb_dt_coef;
    import dt_coef_pkg::*;
    import fp_mul_pkg::*;

    localparam int MAX_STALL   = 6;
    localparam int STEP_CYCLES = 2 * MAX_STALL + 4;           // worst case per step
    localparam int SEQ_CYCLES  = (`NUM_STEPS + 2) * STEP_CYCLES;
    localparam int NUM_SEQS    = 10;
    localparam int NUM_RAND    = 4;
    localparam int WATCHDOG_NS = (NUM_SEQS * `NUM_STEPS * STEP_CYCLES + 200) * 20;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 start;
    logic [`DT_WIDTH-1:0] delta_t;
    logic                 mul_req_valid;
    logic                 mul_req_ready;
    mul_req_t             mul_req;
    logic                 mul_resp_valid;
    logic                 mul_resp_ready;
    mul_resp_t            mul_resp;
    coef_set_t            coefs;
    logic                 done;
    logic                 valid;
    logic                 stall_en;
    logic                 req_stall;
    logic                 resp_stall;
    int                   req_run;
    int                   resp_run;
    logic [31:0]          rng;
    logic [`DT_WIDTH-1:0] rand_dt [NUM_RAND];

    always #10 clk = ~clk;

    dt_coef_top dt_coef_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .delta_t        (delta_t),
        .mul_req_valid  (mul_req_valid),
        .mul_req_ready  (mul_req_ready),
        .mul_req        (mul_req),
        .mul_resp_valid (mul_resp_valid),
        .mul_resp_ready (mul_resp_ready),
        .mul_resp       (mul_resp),
        .coefs          (coefs),
        .done           (done),
        .valid          (valid)
    );

    dt_coef_mul_model mul_model_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_stall  (req_stall),
        .resp_stall (resp_stall),
        .req_valid  (mul_req_valid),
        .req_ready  (mul_req_ready),
        .req        (mul_req),
        .resp_valid (mul_resp_valid),
        .resp_ready (mul_resp_ready),
        .resp       (mul_resp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // random back-pressure, runs capped at MAX_STALL cycles
    always @(posedge clk) begin
        if (stall_en) begin
            rng = lcg_next(rng);
            req_stall  <= rng[16] && (req_run < MAX_STALL);
            resp_stall <= rng[20] && (resp_run < MAX_STALL);
            req_run    <= (rng[16] && req_run < MAX_STALL) ? req_run + 1 : 0;
            resp_run   <= (rng[20] && resp_run < MAX_STALL) ? resp_run + 1 : 0;
        end else begin
            req_stall  <= 1'b0;
            resp_stall <= 1'b0;
            req_run    <= 0;
            resp_run   <= 0;
        end
    end

    // --------------------
    // reference and checks
    // --------------------
    function automatic coef_set_t expected_coefs(input logic [`DT_WIDTH-1:0] dt_bits);
        real       dt;
        real       p2;
        real       p3;
        real       p4;
        coef_set_t c;
        dt = $bitstoreal(dt_bits);
        p2 = dt * dt;
        p3 = p2 * dt;
        p4 = p3 * dt;
        c.dt2         = $realtobits(p2);
        c.delta_t2    = $realtobits(dt * $bitstoreal(`FP_TWO));
        c.half_dt2    = $realtobits(p2 * $bitstoreal(`FP_HALF));
        c.three2_dt2  = $realtobits(p2 * $bitstoreal(`FP_THREE_HALVES));
        c.half_dt3    = $realtobits(p3 * $bitstoreal(`FP_HALF));
        c.third_dt3   = $realtobits(p3 * $bitstoreal(`FP_THIRD));
        c.sixth_dt3   = $realtobits(p3 * $bitstoreal(`FP_SIXTH));
        c.two3_dt3    = $realtobits(p3 * $bitstoreal(`FP_TWO_THIRDS));
        c.quarter_dt4 = $realtobits(p4 * $bitstoreal(`FP_QUARTER));
        c.sixth_dt4   = $realtobits(p4 * $bitstoreal(`FP_SIXTH));
        c.twelfth_dt4 = $realtobits(p4 * $bitstoreal(`FP_TWELFTH));
        c.five12_dt4  = $realtobits(p4 * $bitstoreal(`FP_FIVE_TWELFTHS));
        return c;
    endfunction

    task automatic compare(input string test, input string what,
                           input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: %s expected %h actual %h", test, what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_coefs(input string test, input coef_set_t want);
        compare(test, "delta_t2", want.delta_t2, coefs.delta_t2);
        compare(test, "dt2", want.dt2, coefs.dt2);
        compare(test, "half_dt2", want.half_dt2, coefs.half_dt2);
        compare(test, "three2_dt2", want.three2_dt2, coefs.three2_dt2);
        compare(test, "half_dt3", want.half_dt3, coefs.half_dt3);
        compare(test, "third_dt3", want.third_dt3, coefs.third_dt3);
        compare(test, "sixth_dt3", want.sixth_dt3, coefs.sixth_dt3);
        compare(test, "two3_dt3", want.two3_dt3, coefs.two3_dt3);
        compare(test, "quarter_dt4", want.quarter_dt4, coefs.quarter_dt4);
        compare(test, "sixth_dt4", want.sixth_dt4, coefs.sixth_dt4);
        compare(test, "twelfth_dt4", want.twelfth_dt4, coefs.twelfth_dt4);
        compare(test, "five12_dt4", want.five12_dt4, coefs.five12_dt4);
    endtask

    // start pulse, then valid must be cleared
    task automatic start_seq(input string test, input logic [`DT_WIDTH-1:0] dt);
        @(posedge clk);
        start   <= 1'b1;
        delta_t <= dt;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare(test, "valid after start", 64'd0, 64'(valid));
    endtask

    task automatic wait_done(input string test);
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < SEQ_CYCLES) begin
            compare(test, "valid before done", 64'd0, 64'(valid));
            n++;
            @(negedge clk);
        end
        if (!done) begin
            $display("%s: done did not arrive within %0d cycles", test, SEQ_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_done_pulse(input string test);
        repeat (3) begin
            @(negedge clk);
            compare(test, "done after pulse", 64'd0, 64'(done));
            compare(test, "valid after done", 64'd1, 64'(valid));
        end
    endtask

    task automatic run_and_check(input string test, input logic [`DT_WIDTH-1:0] dt);
        start_seq(test, dt);
        wait_done(test);
        check_coefs(test, expected_coefs(dt));
        check_done_pulse(test);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_reset();
        compare("reset", "done", 64'd0, 64'(done));
        compare("reset", "valid", 64'd0, 64'(valid));
        compare("reset", "mul_req_valid", 64'd0, 64'(mul_req_valid));
        compare("reset", "mul_resp_ready", 64'd0, 64'(mul_resp_ready));
        check_coefs("reset", '0);
    endtask

    task automatic test_fixed_dt();
        run_and_check("fixed_dt", $realtobits(0.5));
    endtask

    task automatic test_random_stalls();
        @(posedge clk);
        stall_en <= 1'b1;
        for (int i = 0; i < NUM_RAND; i++)
            run_and_check("random_stalls", rand_dt[i]);
    endtask

    // second start lands mid sequence
    task automatic test_restart();
        start_seq("restart", $realtobits(3.0));
        repeat (10) @(posedge clk);
        run_and_check("restart", $realtobits(0.2));
    endtask

    task automatic test_second_start();
        coef_set_t old;
        @(posedge clk);
        stall_en <= 1'b0;
        @(negedge clk);
        old = coefs;
        start_seq("second_start", $realtobits(1.75));
        check_coefs("second_start held", old);  // nothing rewritten yet
        wait_done("second_start");
        check_coefs("second_start", expected_coefs($realtobits(1.75)));
        check_done_pulse("second_start");
    endtask

    always @(negedge clk) begin
        if (dt_coef_top_i.asserts_i.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        delta_t    = '0;
        stall_en   = 1'b0;
        req_stall  = 1'b0;
        resp_stall = 1'b0;
        req_run    = 0;
        resp_run   = 0;
        rng        = 32'd32;
        for (int i = 0; i < NUM_RAND; i++) begin
            rng = lcg_next(rng);
            rand_dt[i] = $realtobits(0.001 + real'(rng[30:8]) / 4194304.0);
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset();
        test_fixed_dt();
        test_random_stalls();
        test_restart();
        test_second_start();
        @(negedge clk);
        if (dt_coef_top_i.asserts_i.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
